//--- design/ocl_pkg.sv
/*
 * Shared definitions for the OCL register slave
 * Bus widths, register address map and response codes
 * AXI-Lite channel, register write and miner structs
 */
package ocl_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;
  localparam int led_w  = 16;

  // ----------------------------------------
  // Register map, one word each
  // ----------------------------------------
  localparam logic [addr_w-1:0] hello_reg_addr        = 32'h0000_0500;
  localparam logic [addr_w-1:0] vled_reg_addr         = 32'h0000_0504;
  localparam logic [addr_w-1:0] status_reg_addr       = 32'h0000_0508;
  localparam logic [addr_w-1:0] nonce_reg_addr        = 32'h0000_050C;
  localparam logic [addr_w-1:0] heavyhash_reg_addr    = 32'h0000_0510;
  localparam logic [addr_w-1:0] block_header_reg_addr = 32'h0000_0520;
  localparam logic [addr_w-1:0] matrix_reg_addr       = 32'h0000_0524;
  localparam logic [addr_w-1:0] target_reg_addr       = 32'h0000_0528;
  localparam logic [addr_w-1:0] nonce_size_reg_addr   = 32'h0000_052C;
  localparam logic [addr_w-1:0] start_reg_addr        = 32'h0000_0530;
  localparam logic [addr_w-1:0] stop_reg_addr         = 32'h0000_0534;
  localparam logic [addr_w-1:0] hash_sel_reg_addr     = 32'h0000_0538;

  // Read word for holes in the map
  localparam logic [data_w-1:0] unimpl_reg_value = 32'hDEAD_BEEF;

  // Only response the slave returns
  localparam logic [1:0] resp_okay = 2'b00;

  // ----------------------------------------
  // AXI-Lite channels
  // ----------------------------------------
  // Manager to slave
  typedef struct packed {
    logic              awvalid;
    logic [addr_w-1:0] awaddr;
    logic              wvalid;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              bready;
    logic              arvalid;
    logic [addr_w-1:0] araddr;
    logic              rready;
  } axil_req_t;

  // Slave to manager
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [data_w-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

  // Accepted write beat toward the register block
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } reg_wr_t;

  // ----------------------------------------
  // Miner side
  // ----------------------------------------
  typedef struct packed {
    logic [1:0]        status;
    logic [data_w-1:0] nonce;
    logic [data_w-1:0] heavyhash;
  } miner_stat_t;

  // Write pulses carry data only while high
  typedef struct packed {
    logic              block_header_we;
    logic [data_w-1:0] block_header;
    logic              matrix_we;
    logic [data_w-1:0] matrix_in;
    logic              target_we;
    logic [data_w-1:0] target;
    logic [data_w-1:0] nonce_size;
    logic              start;
    logic              stop;
  } miner_ctrl_t;

endpackage

//--- design/axil_slave.sv
/*
 * AXI-Lite slave, single beat only
 * Write address capture, write data accept and B response
 * Read address register, read word sample and R response
 */
module axil_slave
  import ocl_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  axil_req_t         axil_req,
  output axil_rsp_t         axil_rsp,
  output reg_wr_t           reg_wr,
  output logic              rd_en,
  output logic [addr_w-1:0] rd_addr,
  input  logic [data_w-1:0] rd_data
);

  // Write side
  logic              wr_active;
  logic [addr_w-1:0] wr_addr;
  logic              awready;
  logic              wready;
  logic              bvalid;
  logic              aw_fire;
  logic              b_fire;

  // Read side
  logic              rd_pend;
  logic              arready;
  logic              rvalid;
  logic [data_w-1:0] rdata;
  logic              ar_fire;
  logic              r_fire;

  // ----------------------------------------
  // Write channels
  // ----------------------------------------
  // One write in flight, from AW until B accepted
  assign awready = !wr_active;
  // W taken once per write, never while B waits
  assign wready  = wr_active && !bvalid && axil_req.wvalid;
  assign aw_fire = axil_req.awvalid && awready;
  assign b_fire  = bvalid && axil_req.bready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end
    else
    begin
      if (aw_fire)
        wr_active <= 1'b1;
      else if (b_fire)
        wr_active <= 1'b0;

      // Response the edge after the W beat
      if (wready)
        bvalid <= 1'b1;
      else if (b_fire)
        bvalid <= 1'b0;
    end
  end

  // Address held for the W beat
  always_ff @(posedge clk_main_a0)
  begin
    if (aw_fire)
      wr_addr <= axil_req.awaddr;
  end

  // Register strobe is the W transfer itself; strobes ignored, full word
  assign reg_wr.en   = wready;
  assign reg_wr.addr = wr_addr;
  assign reg_wr.data = axil_req.wdata;

  // ----------------------------------------
  // Read channels
  // ----------------------------------------
  assign arready = !rd_pend && !rvalid;
  assign ar_fire = axil_req.arvalid && arready;
  assign r_fire  = rvalid && axil_req.rready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
    end
    else
    begin
      // Single cycle, AR is blocked while pending
      rd_pend <= ar_fire;
      if (rd_pend)
        rvalid <= 1'b1;
      else if (r_fire)
        rvalid <= 1'b0;
    end
  end

  // Address and read word payload
  always_ff @(posedge clk_main_a0)
  begin
    if (ar_fire)
      rd_addr <= axil_req.araddr;
    if (rd_pend)
      rdata <= rd_data;
  end

  // Read word is sampled in the rd_en cycle
  assign rd_en = rd_pend;

  // ----------------------------------------
  // Response outputs
  // ----------------------------------------
  assign axil_rsp.awready = awready;
  assign axil_rsp.wready  = wready;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.bresp   = resp_okay;
  assign axil_rsp.arready = arready;
  assign axil_rsp.rvalid  = rvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = resp_okay;

  // Responses wait for the manager with payload unchanged
  a_bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !axil_req.bready |=> bvalid);

  a_rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !axil_req.rready |=> rvalid && $stable(rdata));

endmodule

//--- design/ocl_regs.sv
/*
 * OCL register block
 * Scratch register, miner control pulses and held settings
 * Read word multiplexer and hash read-enable pulse
 */
module ocl_regs
  import ocl_pkg::*;
#(
  parameter int blk_cnt = 36
)
(
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  reg_wr_t                    reg_wr,
  input  logic                       rd_en,
  input  logic [addr_w-1:0]          rd_addr,
  output logic [data_w-1:0]          rd_data,
  input  logic [led_w-1:0]           vled_shadow,
  output logic [data_w-1:0]          hello_word,
  output miner_ctrl_t                miner_ctrl,
  output logic [$clog2(blk_cnt)-1:0] hash_sel,
  output logic                       hash_re,
  input  miner_stat_t                miner_stat
);

  localparam int hs_w = $clog2(blk_cnt);

  // Write hits, one per register
  logic wr_hello;
  logic wr_blk_hdr;
  logic wr_matrix;
  logic wr_target;
  logic wr_nonce_size;
  logic wr_start;
  logic wr_stop;
  logic wr_hash_sel;

  logic [data_w-1:0] hello_swap;
  logic [4:0]        pulses;

  // ----------------------------------------
  // Write decode
  // ----------------------------------------
  assign wr_hello      = reg_wr.en && (reg_wr.addr == hello_reg_addr);
  assign wr_blk_hdr    = reg_wr.en && (reg_wr.addr == block_header_reg_addr);
  assign wr_matrix     = reg_wr.en && (reg_wr.addr == matrix_reg_addr);
  assign wr_target     = reg_wr.en && (reg_wr.addr == target_reg_addr);
  assign wr_nonce_size = reg_wr.en && (reg_wr.addr == nonce_size_reg_addr);
  assign wr_start      = reg_wr.en && (reg_wr.addr == start_reg_addr);
  assign wr_stop       = reg_wr.en && (reg_wr.addr == stop_reg_addr);
  assign wr_hash_sel   = reg_wr.en && (reg_wr.addr == hash_sel_reg_addr);

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      hello_word <= '0;
      miner_ctrl <= '0;
      hash_sel   <= '0;
      hash_re    <= 1'b0;
    end
    else
    begin
      // Scratch register
      if (wr_hello)
        hello_word <= reg_wr.data;

      // Pulses last one cycle, data is zero when idle
      miner_ctrl.block_header_we <= wr_blk_hdr;
      miner_ctrl.block_header    <= wr_blk_hdr ? reg_wr.data : '0;
      miner_ctrl.matrix_we       <= wr_matrix;
      miner_ctrl.matrix_in       <= wr_matrix ? reg_wr.data : '0;
      miner_ctrl.target_we       <= wr_target;
      miner_ctrl.target          <= wr_target ? reg_wr.data : '0;
      miner_ctrl.start           <= wr_start;
      miner_ctrl.stop            <= wr_stop;

      // Held settings
      if (wr_nonce_size)
        miner_ctrl.nonce_size <= reg_wr.data;
      if (wr_hash_sel)
        hash_sel <= reg_wr.data[hs_w-1:0];

      // Lines up with rvalid rising in the slave
      hash_re <= rd_en && (rd_addr == heavyhash_reg_addr);
    end
  end

  // ----------------------------------------
  // Read word
  // ----------------------------------------
  // Scratch reads back with bytes reversed
  assign hello_swap = {<<8{hello_word}};

  always_comb
  begin
    case (rd_addr)
      hello_reg_addr:
        rd_data = hello_swap;
      vled_reg_addr:
        rd_data = {{(data_w-led_w){1'b0}}, vled_shadow};
      status_reg_addr:
        rd_data = {{(data_w-2){1'b0}}, miner_stat.status};
      nonce_reg_addr:
        rd_data = miner_stat.nonce;
      heavyhash_reg_addr:
        rd_data = miner_stat.heavyhash;
      default:
        rd_data = unimpl_reg_value;
    endcase
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  assign pulses = {miner_ctrl.block_header_we, miner_ctrl.matrix_we, miner_ctrl.target_we,
                   miner_ctrl.start, miner_ctrl.stop};

  a_start_stop: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(miner_ctrl.start && miner_ctrl.stop));

  // Relies on the slave never taking two W beats back to back
  a_pulse_once: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (pulses & $past(pulses)) == '0);

endmodule

//--- design/vled_status.sv
/*
 * Virtual LED status
 * DIP switch synchronizer, LED shadow of the scratch register
 * LED output masked by the switches
 */
module vled_status
  import ocl_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic [data_w-1:0] hello_word,
  input  logic [led_w-1:0]  vdip,
  output logic [led_w-1:0]  vled_shadow,
  output logic [led_w-1:0]  status_vled
);

  // Two flops on the switch inputs
  logic [led_w-1:0] vdip_q;
  logic [led_w-1:0] vdip_q2;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vdip_q      <= '0;
      vdip_q2     <= '0;
      vled_shadow <= '0;
      status_vled <= '0;
    end
    else
    begin
      vdip_q  <= vdip;
      vdip_q2 <= vdip_q;

      // Low half of scratch, also read back
      vled_shadow <= hello_word[led_w-1:0];

      // Switch off masks the LED
      status_vled <= vled_shadow & vdip_q2;
    end
  end

endmodule

//--- design/cl_ocl_top.sv
/*
 * OCL register top level
 * AXI-Lite slave, register block and virtual LED logic
 */
module cl_ocl_top
  import ocl_pkg::*;
#(
  parameter int blk_cnt = 36
)
(
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  axil_req_t                  axil_req,
  output axil_rsp_t                  axil_rsp,
  output miner_ctrl_t                miner_ctrl,
  output logic [$clog2(blk_cnt)-1:0] hash_sel,
  output logic                       hash_re,
  input  miner_stat_t                miner_stat,
  input  logic [led_w-1:0]           vdip,
  output logic [led_w-1:0]           status_vled
);

  // Slave to register block
  reg_wr_t           reg_wr;
  logic              rd_en;
  logic [addr_w-1:0] rd_addr;
  logic [data_w-1:0] rd_data;

  // Register block to LED logic and back
  logic [data_w-1:0] hello_word;
  logic [led_w-1:0]  vled_shadow;

  // ----------------------------------------
  // Bus slave
  // ----------------------------------------
  axil_slave u_axil_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .axil_req        (axil_req),
    .axil_rsp        (axil_rsp),
    .reg_wr          (reg_wr),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // ----------------------------------------
  // Registers and miner control
  // ----------------------------------------
  ocl_regs #(
    .blk_cnt (blk_cnt)
  ) u_ocl_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .vled_shadow     (vled_shadow),
    .hello_word      (hello_word),
    .miner_ctrl      (miner_ctrl),
    .hash_sel        (hash_sel),
    .hash_re         (hash_re),
    .miner_stat      (miner_stat)
  );

  // Virtual LEDs
  vled_status u_vled_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_word      (hello_word),
    .vdip            (vdip),
    .vled_shadow     (vled_shadow),
    .status_vled     (status_vled)
  );

endmodule

//--- dv/tb_cl_ocl_top.sv
/*
 * Testbench for the OCL register top level
 * Clock, reset, AXI-Lite write and read tasks
 * Port monitor models and concurrent checking assertions
 */
module tb_cl_ocl_top
  import ocl_pkg::*;
();

  localparam int blk_cnt    = 36;
  localparam int hs_w       = $clog2(blk_cnt);
  localparam int wait_limit = 200;

  logic             clk_main_a0;
  logic             rst_main_n_sync;
  axil_req_t        bus_req;
  axil_rsp_t        bus_rsp;
  miner_ctrl_t      miner_ctrl;
  logic [hs_w-1:0]  hash_sel;
  logic             hash_re;
  miner_stat_t      miner_stat;
  logic [led_w-1:0] vdip;
  logic [led_w-1:0] status_vled;
  int               seed = 32'h0a856670;

  // Reference state built from handshakes seen at the ports
  logic [data_w-1:0] hello_ref;
  logic [data_w-1:0] nonce_size_ref;
  logic [hs_w-1:0]   hash_sel_ref;
  logic [addr_w-1:0] wr_addr_mon;
  logic [addr_w-1:0] rd_addr_mon;
  logic              wr_open;
  logic              wr_seen;
  logic [addr_w-1:0] wr_seen_addr;
  logic [data_w-1:0] wr_seen_data;
  logic [2:0]        hello_age;
  logic [2:0]        dip_age;
  // Switch value as of the last edge
  logic [led_w-1:0]  dip_last;

  logic aw_fire;
  logic w_fire;
  logic ar_fire;

  assign aw_fire = bus_req.awvalid && bus_rsp.awready;
  assign w_fire  = bus_req.wvalid && bus_rsp.wready;
  assign ar_fire = bus_req.arvalid && bus_rsp.arready;

  cl_ocl_top #(
    .blk_cnt (blk_cnt)
  ) DUT (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .axil_req        (bus_req),
    .axil_rsp        (bus_rsp),
    .miner_ctrl      (miner_ctrl),
    .hash_sel        (hash_sel),
    .hash_re         (hash_re),
    .miner_stat      (miner_stat),
    .vdip            (vdip),
    .status_vled     (status_vled)
  );

  initial
  begin
    clk_main_a0 = 1'b0;
    forever #4 clk_main_a0 = ~clk_main_a0;
  end

  // ----------------------------------------
  // Expected values
  // ----------------------------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Read word per register map
  function automatic logic [data_w-1:0] exp_read(input logic [addr_w-1:0] addr,
    input logic [data_w-1:0] hello, input miner_stat_t stat);
    case (addr)
      hello_reg_addr:     exp_read = {hello[7:0], hello[15:8], hello[23:16], hello[31:24]};
      vled_reg_addr:      exp_read = {16'h0000, hello[15:0]};
      status_reg_addr:    exp_read = {30'h0, stat.status};
      nonce_reg_addr:     exp_read = stat.nonce;
      heavyhash_reg_addr: exp_read = stat.heavyhash;
      default:            exp_read = unimpl_reg_value;
    endcase
  endfunction

  // Pulse one cycle after the W beat with data only while pulsing
  function automatic miner_ctrl_t exp_ctrl(input logic seen, input logic [addr_w-1:0] addr,
    input logic [data_w-1:0] data, input logic [data_w-1:0] nonce_size);
    miner_ctrl_t c;
    c                 = '0;
    c.block_header_we = seen && (addr == block_header_reg_addr);
    c.block_header    = c.block_header_we ? data : '0;
    c.matrix_we       = seen && (addr == matrix_reg_addr);
    c.matrix_in       = c.matrix_we ? data : '0;
    c.target_we       = seen && (addr == target_reg_addr);
    c.target          = c.target_we ? data : '0;
    c.start           = seen && (addr == start_reg_addr);
    c.stop            = seen && (addr == stop_reg_addr);
    c.nonce_size      = nonce_size;
    return c;
  endfunction

  // ----------------------------------------
  // Port monitor
  // ----------------------------------------
  always @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      hello_ref      <= '0;
      nonce_size_ref <= '0;
      hash_sel_ref   <= '0;
      wr_addr_mon    <= '0;
      rd_addr_mon    <= '0;
      wr_open        <= 1'b0;
      wr_seen        <= 1'b0;
      hello_age      <= '0;
      dip_age        <= '0;
      dip_last       <= vdip;
    end
    else
    begin
      wr_seen  <= w_fire;
      dip_last <= vdip;
      if (aw_fire)
        wr_addr_mon <= bus_req.awaddr;
      if (ar_fire)
        rd_addr_mon <= bus_req.araddr;
      // Data phase open from AW until the W beat
      if (aw_fire)
        wr_open <= 1'b1;
      else if (w_fire)
        wr_open <= 1'b0;
      // Ages saturate at 7 and restart at zero on a change
      if (hello_age != 3'd7)
        hello_age <= hello_age + 3'd1;
      if (dip_age != 3'd7)
        dip_age <= dip_age + 3'd1;
      if (vdip != dip_last)
        dip_age <= '0;
      if (w_fire)
      begin
        wr_seen_addr <= wr_addr_mon;
        wr_seen_data <= bus_req.wdata;
        if (wr_addr_mon == hello_reg_addr)
        begin
          hello_ref <= bus_req.wdata;
          hello_age <= '0;
        end
        if (wr_addr_mon == nonce_size_reg_addr)
          nonce_size_ref <= bus_req.wdata;
        if (wr_addr_mon == hash_sel_reg_addr)
          hash_sel_ref <= bus_req.wdata[hs_w-1:0];
      end
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_reset_idle: assert property (@(posedge clk_main_a0) $rose(rst_main_n_sync) |->
    !bus_rsp.bvalid && !bus_rsp.rvalid && !bus_rsp.wready && bus_rsp.awready &&
    bus_rsp.arready && miner_ctrl == '0 && !hash_re && status_vled == '0)
    else abort_run($sformatf("FAILED at %0t: outputs not idle after reset", $time));

  // W accepted only between AW and the single data beat
  a_w_ready: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bus_rsp.wready == (wr_open && bus_req.wvalid))
    else abort_run($sformatf("FAILED at %0t: wready outside the write data phase", $time));

  a_b_resp: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (wr_seen == $rose(bus_rsp.bvalid)) && bus_rsp.bresp == resp_okay)
    else abort_run($sformatf("FAILED at %0t: write response timing or code", $time));

  a_b_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bus_rsp.bvalid && !bus_req.bready |=> bus_rsp.bvalid && $stable(bus_rsp.bresp))
    else abort_run($sformatf("FAILED at %0t: bvalid dropped before bready", $time));

  a_busy: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (!bus_rsp.bvalid || !bus_rsp.awready) && (!bus_rsp.rvalid || !bus_rsp.arready))
    else abort_run($sformatf("FAILED at %0t: address accepted while busy", $time));

  a_r_timing: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ar_fire |=> !bus_rsp.rvalid ##1 bus_rsp.rvalid)
    else abort_run($sformatf("FAILED at %0t: rvalid not 2 cycles after AR", $time));

  a_r_data: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $rose(bus_rsp.rvalid) |-> bus_rsp.rresp == resp_okay &&
    bus_rsp.rdata == exp_read(rd_addr_mon, hello_ref, miner_stat))
    else abort_run($sformatf("FAILED at %0t: read data %h at address %h", $time,
      bus_rsp.rdata, rd_addr_mon));

  a_r_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bus_rsp.rvalid && !bus_req.rready |=> bus_rsp.rvalid && $stable(bus_rsp.rdata))
    else abort_run($sformatf("FAILED at %0t: read response changed while stalled", $time));

  a_hash_re: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    hash_re == ($rose(bus_rsp.rvalid) && rd_addr_mon == heavyhash_reg_addr))
    else abort_run($sformatf("FAILED at %0t: hash_re pulse wrong", $time));

  a_ctrl: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    miner_ctrl == exp_ctrl(wr_seen, wr_seen_addr, wr_seen_data, nonce_size_ref) &&
    hash_sel == hash_sel_ref)
    else abort_run($sformatf("FAILED at %0t: miner control outputs wrong", $time));

  // Settled scratch and switches give the masked LEDs
  a_vled: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    hello_age >= 3'd2 && dip_age >= 3'd2 |-> status_vled == (hello_ref[led_w-1:0] & dip_last))
    else abort_run($sformatf("FAILED at %0t: status_vled %h", $time, status_vled));

  // ----------------------------------------
  // Bus tasks
  // ----------------------------------------
  task automatic axil_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    int   cnt;
    int   stall;
    logic aw_done;
    logic w_done;
    stall   = $unsigned($random(seed)) % 5;
    cnt     = 0;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(negedge clk_main_a0);
    bus_req.awvalid = 1'b1;
    bus_req.awaddr  = addr;
    bus_req.wvalid  = 1'b1;
    bus_req.wdata   = data;
    // AW and W finish in different cycles
    while (!(aw_done && w_done))
    begin
      @(posedge clk_main_a0);
      aw_done = aw_done || aw_fire;
      w_done  = w_done || w_fire;
      @(negedge clk_main_a0);
      bus_req.awvalid = !aw_done;
      bus_req.wvalid  = !w_done;
      cnt++;
      if (cnt > wait_limit)
        abort_run("Timed out waiting for the write address or data handshake");
    end
    // Stall on bready, then take the response
    repeat (stall) @(negedge clk_main_a0);
    bus_req.bready = 1'b1;
    cnt = 0;
    @(posedge clk_main_a0);
    while (!bus_rsp.bvalid)
    begin
      cnt++;
      if (cnt > wait_limit)
        abort_run("Timed out waiting for the write response");
      @(posedge clk_main_a0);
    end
    @(negedge clk_main_a0);
    bus_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [addr_w-1:0] addr);
    int cnt;
    int stall;
    stall = $unsigned($random(seed)) % 5;
    cnt   = 0;
    @(negedge clk_main_a0);
    bus_req.arvalid = 1'b1;
    bus_req.araddr  = addr;
    @(posedge clk_main_a0);
    while (!ar_fire)
    begin
      cnt++;
      if (cnt > wait_limit)
        abort_run("Timed out waiting for the read address handshake");
      @(posedge clk_main_a0);
    end
    @(negedge clk_main_a0);
    bus_req.arvalid = 1'b0;
    repeat (stall) @(negedge clk_main_a0);
    bus_req.rready = 1'b1;
    cnt = 0;
    @(posedge clk_main_a0);
    while (!bus_rsp.rvalid)
    begin
      cnt++;
      if (cnt > wait_limit)
        abort_run("Timed out waiting for the read response");
      @(posedge clk_main_a0);
    end
    @(negedge clk_main_a0);
    bus_req.rready = 1'b0;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial
  begin
    logic [31:0] rnd;
    bus_req         = '0;
    bus_req.wstrb   = '1;
    miner_stat      = '0;
    vdip            = '0;
    rst_main_n_sync = 1'b0;
    repeat (10) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;

    // Scratch and holes in the map
    repeat (4)
    begin
      rnd = $random(seed);
      axil_write(hello_reg_addr, rnd);
      axil_read(hello_reg_addr);
    end
    axil_read(32'h0000_0600);
    axil_read(32'h0000_0514);

    // Miner pulses, then held settings across other writes
    axil_write(block_header_reg_addr, $random(seed));
    axil_write(matrix_reg_addr, $random(seed));
    axil_write(target_reg_addr, $random(seed));
    axil_write(start_reg_addr, $random(seed));
    axil_write(stop_reg_addr, $random(seed));
    axil_write(nonce_size_reg_addr, $random(seed));
    axil_write(hash_sel_reg_addr, $random(seed));
    axil_write(target_reg_addr, $random(seed));
    axil_write(start_reg_addr, $random(seed));

    // Miner status read back
    repeat (3)
    begin
      @(negedge clk_main_a0);
      rnd                  = $random(seed);
      miner_stat.status    = rnd[1:0];
      miner_stat.nonce     = $random(seed);
      miner_stat.heavyhash = $random(seed);
      axil_read(status_reg_addr);
      axil_read(nonce_reg_addr);
      axil_read(heavyhash_reg_addr);
    end

    // Virtual LEDs under random switch patterns
    repeat (3)
    begin
      axil_write(hello_reg_addr, $random(seed));
      @(negedge clk_main_a0);
      rnd  = $random(seed);
      vdip = rnd[led_w-1:0];
      repeat (4) @(negedge clk_main_a0);
      axil_read(vled_reg_addr);
    end

    repeat (5) @(posedge clk_main_a0);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- build.f
design/ocl_pkg.sv
design/axil_slave.sv
design/ocl_regs.sv
design/vled_status.sv
design/cl_ocl_top.sv
dv/tb_cl_ocl_top.sv
